//--- board_cfg.svh
`ifndef BOARD_CFG_SVH
`define BOARD_CFG_SVH

// --------------------
// Clocking

`define BOARD_CLK_MHZ  50                          // System clock in MHz
`define SLOW_CLK_DIV   (`BOARD_CLK_MHZ * 500000)   // Half period of slow_clk, 1 Hz on hardware
`define MIC_SCK_DIV    8                           // Half period of mic sck
`define DAC_BCLK_DIV   8                           // Half period of DAC bclk
`define TM_CLK_DIV     4                           // Half period of TM1638 sio_clk

// --------------------
// Board resources

`define TM_DIGITS      8                           // Digits on the TM1638 module
`define W_KEY          2                           // Onboard keys, active low
`define W_SW           4                           // Onboard switches
`define W_LED          8                           // Onboard LEDs

`endif

//--- board_pkg.sv
`include "board_cfg.svh"

package board_pkg;

    // --------------------
    // Keys and LEDs

    typedef logic [7:0] key_t;   // Merged key vector
    typedef logic [7:0] led_t;   // One bit per LED

    // --------------------
    // Display

    typedef logic [7:0] seg_t;   // Segments a..h, a in MSB

    typedef struct packed {
        seg_t [`TM_DIGITS - 1:0] digit;   // Digit 7 is leftmost
        led_t                    leds;
    } disp_t;

endpackage

//--- audio_pkg.sv
package audio_pkg;

    // --------------------
    // Sample formats

    typedef logic signed [23:0] mic_sample_t;   // INMP441 word, two's complement
    typedef logic signed [15:0] dac_sample_t;   // DAC word

    // --------------------
    // One beat toward the DAC

    typedef struct packed {
        dac_sample_t sample;
        logic        clip;                      // Set when doubling saturated
    } audio_beat_t;

endpackage

//--- slow_clk_gen.sv
`include "board_cfg.svh"

module slow_clk_gen
(
    input  logic clk,
    input  logic rst,
    output logic slow_clk
);

    localparam int W_CNT = $clog2(`SLOW_CLK_DIV + 1);

    logic [W_CNT - 1:0] cnt;   // Cycles in the current half period

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            cnt      <= '0;
            slow_clk <= 1'b0;
        end
        else if (cnt == W_CNT'(`SLOW_CLK_DIV - 1))
        begin
            cnt      <= '0;
            slow_clk <= ~slow_clk;          // Half period done
        end
        else
        begin
            cnt      <= cnt + 1'b1;
        end
    end

endmodule

//--- inmp441_mic_i2s_receiver.sv
`include "board_cfg.svh"

module inmp441_mic_i2s_receiver
(
    input  logic                   clk,
    input  logic                   rst,
    output logic                   lr,
    output logic                   ws,
    output logic                   sck,
    input  logic                   sd,
    output logic                   valid,
    input  logic                   ready,
    output audio_pkg::mic_sample_t value
);

    localparam int W_DIV = $clog2(`MIC_SCK_DIV + 1);

    logic [W_DIV - 1:0]     div_cnt;    // Cycles in the sck half period
    logic                   sck_edge;   // sck toggles at this edge
    logic                   sck_rise;
    logic [5:0]             bit_cnt;    // sck period within the frame
    logic                   in_word;    // Period carries a left data bit
    logic                   last_bit;   // 24th bit just shifted in
    audio_pkg::mic_sample_t shreg;

    assign lr       = 1'b0;                  // Mic set to left channel
    assign ws       = bit_cnt[5];            // Low in the left slot
    assign sck_edge = div_cnt == W_DIV'(`MIC_SCK_DIV - 1);
    assign sck_rise = sck_edge && !sck;
    assign in_word  = bit_cnt >= 6'd1 && bit_cnt <= 6'd24;   // One bit of I2S delay

    // --------------------
    // Clock and frame counters

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            div_cnt <= '0;
            sck     <= 1'b0;
            bit_cnt <= '0;
        end
        else if (sck_edge)
        begin
            div_cnt <= '0;
            sck     <= ~sck;
            if (sck)
                bit_cnt <= bit_cnt + 1'b1;   // ws moves on falling sck
        end
        else
        begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // --------------------
    // Deserializer

    always_ff @(posedge clk)
    begin
        if (sck_rise && in_word)
            shreg <= {shreg[22:0], sd};      // MSB arrives first
        if (last_bit)
            value <= shreg;                  // Newest frame overwrites
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            last_bit <= 1'b0;
            valid    <= 1'b0;
        end
        else
        begin
            last_bit <= sck_rise && bit_cnt == 6'd24;
            if (last_bit)
                valid <= 1'b1;
            else if (ready)
                valid <= 1'b0;               // Taken by the core
        end
    end

endmodule

//--- i2s_audio_out.sv
`include "board_cfg.svh"

module i2s_audio_out
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   beat_valid,
    output logic                   beat_ready,
    input  audio_pkg::audio_beat_t beat,
    output logic                   mclk,
    output logic                   bclk,
    output logic                   lrclk,
    output logic                   sdata
);

    localparam int W_DIV = $clog2(`DAC_BCLK_DIV + 1);

    logic [W_DIV - 1:0]     div_cnt;
    logic                   div_end;
    logic                   bclk_fall;   // bclk goes low at this edge
    logic [4:0]             bit_cnt;     // bclk period within the frame
    logic [4:0]             nxt_cnt;
    logic [3:0]             idx;         // Bit of word sent in the next period
    audio_pkg::dac_sample_t word;        // Sample of the current frame

    assign div_end    = div_cnt == W_DIV'(`DAC_BCLK_DIV - 1);
    assign bclk_fall  = div_end && bclk;
    assign nxt_cnt    = bit_cnt + 5'd1;
    assign idx        = 4'd0 - nxt_cnt[3:0];          // Period 1 gets bit 15
    assign lrclk      = bit_cnt[4];                   // Low in the left slot
    assign beat_ready = bclk_fall && bit_cnt == 5'd31;   // Frame start

    // --------------------
    // Clocks

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            mclk    <= 1'b0;
            div_cnt <= '0;
            bclk    <= 1'b0;
            bit_cnt <= '0;
        end
        else
        begin
            mclk <= ~mclk;                   // clk / 2
            if (div_end)
            begin
                div_cnt <= '0;
                bclk    <= ~bclk;
                if (bclk)
                    bit_cnt <= nxt_cnt;
            end
            else
            begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    // --------------------
    // Sample load and serializer

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            word  <= '0;
            sdata <= 1'b0;
        end
        else
        begin
            if (beat_ready && beat_valid)
                word <= beat.sample;         // Else the old sample repeats
            if (bclk_fall)
                sdata <= word[idx];          // Period 0 carries the previous LSB
        end
    end

endmodule

//--- tm1638_board_controller.sv
`include "board_cfg.svh"

module tm1638_board_controller
(
    input  logic               clk,
    input  logic               rst,
    input  board_pkg::disp_t   disp,
    output board_pkg::key_t    keys,
    output logic               sio_stb,
    output logic               sio_clk,
    inout  wire                sio_data
);

    localparam int W_DIV = $clog2(`TM_CLK_DIV + 1);

    typedef enum logic [1:0] {
        ST_GAP,                      // Strobe high between commands
        ST_HIGH,                     // sio_clk high
        ST_LOW,                      // sio_clk low, data valid
        ST_END                       // Last bit done, strobe still low
    } state_t;

    state_t             state;
    logic [W_DIV - 1:0] div_cnt;
    logic               tick;        // One sio_clk half period passed
    logic [1:0]         cmd;         // Command within the scan
    logic [4:0]         byte_idx;    // 0 is the command byte
    logic [2:0]         bit_idx;
    logic [4:0]         last_byte;
    logic               rd_phase;    // Key bytes are clocked in
    logic [3:0]         pos;         // Display address
    board_pkg::seg_t    seg;
    logic [7:0]         tx_byte;
    logic               data_out;
    logic               data_oe;
    logic [31:0]        rx_data;     // Four key bytes, LSB first
    board_pkg::key_t    key_nxt;

    assign sio_data = data_oe ? data_out : 1'bz;
    assign tick     = div_cnt == W_DIV'(`TM_CLK_DIV - 1);
    assign rd_phase = cmd == 2'd3 && byte_idx != 5'd0;
    assign pos      = 4'(byte_idx - 5'd1);
    assign seg      = disp.digit[3'(`TM_DIGITS - 1) - pos[3:1]];   // Leftmost digit first

    // --------------------
    // Byte to send

    always_comb
    begin
        tx_byte   = 8'h00;
        last_byte = 5'd0;
        case (cmd)
            2'd0: tx_byte = 8'h40;                       // Write, auto increment
            2'd1:
            begin
                last_byte = 5'(2 * `TM_DIGITS);
                if (byte_idx == 5'd0)
                    tx_byte = 8'hC0;                     // Start at address 0
                else if (pos[0])
                    tx_byte = {7'd0, disp.leds[3'(`TM_DIGITS - 1) - pos[3:1]]};
                else
                    for (int b = 0; b < 8; b++)
                        tx_byte[b] = seg[7 - b];         // Device wants a in bit 0
            end
            2'd2: tx_byte = 8'h8F;                       // Display on, full bright
            default:
            begin
                tx_byte   = 8'h42;                       // Read keys
                last_byte = 5'd4;
            end
        endcase
    end

    // Key k sits in byte k mod 4
    always_comb
    begin
        for (int k = 0; k < 8; k++)
            key_nxt[k] = rx_data[(k % 4) * 8 + (k < 4 ? 0 : 4)];
    end

    // --------------------
    // Serial FSM

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            div_cnt  <= '0;
            state    <= ST_GAP;
            cmd      <= '0;
            byte_idx <= '0;
            bit_idx  <= '0;
            sio_stb  <= 1'b1;
            sio_clk  <= 1'b1;
            data_oe  <= 1'b0;
            data_out <= 1'b1;
            keys     <= '0;
        end
        else
        begin
            div_cnt <= tick ? '0 : div_cnt + 1'b1;
            if (tick)
            begin
                case (state)
                    ST_GAP:
                    begin
                        sio_stb <= 1'b0;                 // Command starts
                        state   <= ST_HIGH;
                    end
                    ST_HIGH:
                    begin
                        sio_clk  <= 1'b0;
                        data_oe  <= !rd_phase;           // Release the line for keys
                        data_out <= tx_byte[bit_idx];
                        state    <= ST_LOW;
                    end
                    ST_LOW:
                    begin
                        sio_clk <= 1'b1;                 // Rising edge, both ways
                        bit_idx <= bit_idx + 1'b1;
                        state   <= ST_HIGH;
                        if (bit_idx == 3'd7)
                        begin
                            if (byte_idx == last_byte)
                                state <= ST_END;
                            else
                                byte_idx <= byte_idx + 1'b1;
                        end
                    end
                    default:
                    begin
                        sio_stb  <= 1'b1;
                        data_oe  <= 1'b0;
                        byte_idx <= '0;
                        cmd      <= cmd + 1'b1;          // Wraps to a new scan
                        if (cmd == 2'd3)
                            keys <= key_nxt;             // Held until next scan
                        state    <= ST_GAP;
                    end
                endcase
            end
        end
    end

    // Key bits sampled at the rising sio_clk
    always_ff @(posedge clk)
    begin
        if (tick && state == ST_LOW && rd_phase)
            rx_data[{2'(byte_idx - 5'd1), bit_idx}] <= sio_data;
    end

endmodule

//--- lab_top.sv
module lab_top
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   slow_clk,
    input  board_pkg::key_t        key,
    input  logic [2:0]             sw,
    input  logic                   mic_valid,
    output logic                   mic_ready,
    input  audio_pkg::mic_sample_t mic_sample,
    output logic                   beat_valid,
    input  logic                   beat_ready,
    output audio_pkg::audio_beat_t beat,
    output board_pkg::disp_t       disp
);

    audio_pkg::dac_sample_t upper;      // Top 16 mic bits
    audio_pkg::dac_sample_t shifted;
    audio_pkg::audio_beat_t beat_nxt;
    audio_pkg::dac_sample_t mic_hi;     // Last accepted, for the display
    logic [2:0]             slow_sync;  // Two sync stages and one for the edge
    logic [15:0]            tick_cnt;
    logic                   mic_take;

    // Hex digit to segments, a in MSB
    function automatic board_pkg::seg_t hex_seg(input logic [3:0] h);
        case (h)
            4'h0: hex_seg = 8'hFC;
            4'h1: hex_seg = 8'h60;
            4'h2: hex_seg = 8'hDA;
            4'h3: hex_seg = 8'hF2;
            4'h4: hex_seg = 8'h66;
            4'h5: hex_seg = 8'hB6;
            4'h6: hex_seg = 8'hBE;
            4'h7: hex_seg = 8'hE0;
            4'h8: hex_seg = 8'hFE;
            4'h9: hex_seg = 8'hF6;
            4'hA: hex_seg = 8'hEE;
            4'hB: hex_seg = 8'h3E;
            4'hC: hex_seg = 8'h9C;
            4'hD: hex_seg = 8'h7A;
            4'hE: hex_seg = 8'h9E;
            default: hex_seg = 8'h8E;
        endcase
    endfunction

    // --------------------
    // Audio scaling

    assign mic_ready = !beat_valid || beat_ready;   // Slot empty or leaving
    assign mic_take  = mic_valid && mic_ready;
    assign upper     = mic_sample[23:8];
    assign shifted   = upper >>> sw[1:0];           // Attenuate by 2^sw

    always_comb
    begin
        beat_nxt.sample = shifted;
        beat_nxt.clip   = 1'b0;
        if (sw[2])
        begin
            if (shifted[15] != shifted[14])
            begin
                beat_nxt.sample = shifted[15] ? 16'sh8000 : 16'sh7FFF;   // Saturate
                beat_nxt.clip   = 1'b1;
            end
            else
            begin
                beat_nxt.sample = shifted <<< 1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (mic_take)
        begin
            beat   <= beat_nxt;
            mic_hi <= upper;
        end
    end

    // --------------------
    // Control and tick counter

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            beat_valid <= 1'b0;
            slow_sync  <= '0;
            tick_cnt   <= '0;
        end
        else
        begin
            if (mic_take)
                beat_valid <= 1'b1;
            else if (beat_ready)
                beat_valid <= 1'b0;
            slow_sync <= {slow_sync[1:0], slow_clk};
            if (slow_sync[1] && !slow_sync[2])
                tick_cnt <= tick_cnt + 1'b1;     // Rising slow_clk
        end
    end

    // --------------------
    // Display

    always_comb
    begin
        for (int i = 0; i < 4; i++)
        begin
            disp.digit[i + 4] = hex_seg(mic_hi[i * 4 +: 4]);
            disp.digit[i]     = hex_seg(tick_cnt[i * 4 +: 4]);
        end
        disp.leds = key;                         // LEDs mirror keys
    end

endmodule

//--- board_top.sv
`include "board_cfg.svh"

module board_top
(
    input  logic                clk,
    input  logic                rst,
    input  logic [`W_KEY - 1:0] key,        // Active low
    input  logic [`W_SW  - 1:0] sw,         // Top switch spare, rst has its own pin
    output logic [`W_LED - 1:0] led,
    output logic                mic_lr,
    output logic                mic_ws,
    output logic                mic_sck,
    input  logic                mic_sd,
    output logic                dac_mclk,
    output logic                dac_bclk,
    output logic                dac_lrclk,
    output logic                dac_sdata,
    output logic                tm_stb,
    output logic                tm_clk,
    inout  wire                 tm_dio
);

    logic                   slow_clk;
    board_pkg::key_t        tm_key;
    board_pkg::key_t        top_key;   // Onboard and TM1638 keys
    board_pkg::disp_t       disp;
    logic                   mic_valid;
    logic                   mic_ready;
    audio_pkg::mic_sample_t mic_sample;
    logic                   beat_valid;
    logic                   beat_ready;
    audio_pkg::audio_beat_t beat;

    // --------------------
    // Key and LED merge

    always_comb
    begin
        top_key = tm_key;
        top_key[`W_KEY - 1:0] |= ~key;      // Pressed key reads low
    end

    assign led = disp.leds[`W_LED - 1:0];   // Same LEDs on board and module

    // --------------------
    // Blocks

    slow_clk_gen i_slow_clk_gen (.clk, .rst, .slow_clk);

    inmp441_mic_i2s_receiver i_mic
    (
        .clk   (clk),        .rst   (rst),
        .lr    (mic_lr),     .ws    (mic_ws),
        .sck   (mic_sck),    .sd    (mic_sd),
        .valid (mic_valid),  .ready (mic_ready),
        .value (mic_sample)
    );

    lab_top i_lab_top
    (
        .clk, .rst, .slow_clk, .key (top_key), .sw (sw[2:0]),
        .mic_valid, .mic_ready, .mic_sample,
        .beat_valid, .beat_ready, .beat, .disp
    );

    i2s_audio_out i_dac
    (
        .clk, .rst, .beat_valid, .beat_ready, .beat,
        .mclk (dac_mclk), .bclk (dac_bclk), .lrclk (dac_lrclk), .sdata (dac_sdata)
    );

    tm1638_board_controller i_tm
    (
        .clk, .rst, .disp, .keys (tm_key),
        .sio_stb (tm_stb), .sio_clk (tm_clk), .sio_data (tm_dio)
    );

endmodule

//--- tb_board_top.sv
module tb_board_top;

    timeunit 1ns;
    timeprecision 1ps;

    // Hex digit to segments with a in MSB
    localparam logic [7:0] seg_tab [16] = '{
        8'hFC, 8'h60, 8'hDA, 8'hF2, 8'h66, 8'hB6, 8'hBE, 8'hE0,
        8'hFE, 8'hF6, 8'hEE, 8'h3E, 8'h9C, 8'h7A, 8'h9E, 8'h8E};

    logic       clk;
    logic       rst;
    logic [1:0] key;                // Active low
    logic [3:0] sw;
    logic [7:0] led;
    logic       mic_lr;
    logic       mic_ws;
    logic       mic_sck;
    logic       mic_sd;
    logic       dac_mclk;
    logic       dac_bclk;
    logic       dac_lrclk;
    logic       dac_sdata;
    logic       tm_stb;
    logic       tm_clk;
    wire        tm_dio;

    int          seed = 88968;
    int          chk_cnt = 0;
    int          err_cnt = 0;
    logic        timed_out = 1'b0;
    logic        finished = 1'b0;

    logic [23:0] mic_q[$];          // Words still to send
    logic [23:0] mic_word = '0;
    int          mic_pos = 63;
    logic        mic_sck_d = 1'b0;
    logic        mic_ws_d = 1'b0;

    logic [15:0] dac_q[$];          // Left words seen on the DAC
    logic [15:0] dac_sh = '0;
    int          dac_per = 100;
    logic        bclk_d = 1'b0;
    logic        lrclk_d = 1'b0;

    logic [7:0]  key_bytes [4];     // Returned during a key read
    logic [7:0]  tm_bytes [17];
    logic [7:0]  scan_mem [16];     // Display bytes of the last full scan
    logic [7:0]  tm_sh = '0;
    int          tm_nbits = 0;
    int          tm_nbytes = 0;
    int          rd_cnt = 0;
    int          scan_cnt = 0;
    logic        tm_rd = 1'b0;
    logic        tm_oe;
    logic        tm_dout;
    logic        stb_d = 1'b1;
    logic        tm_clk_d = 1'b1;

    assign tm_dio = tm_oe ? tm_dout : 1'bz;

    board_top dut_i
    (
        .clk, .rst, .key, .sw, .led,
        .mic_lr, .mic_ws, .mic_sck, .mic_sd,
        .dac_mclk, .dac_bclk, .dac_lrclk, .dac_sdata,
        .tm_stb, .tm_clk, .tm_dio
    );

    always #10 clk = ~clk;

    // --------------------
    // Microphone model shifting data out on falling sck
    always @(posedge clk)
    begin
        if (mic_sck_d && !mic_sck)
        begin
            if (mic_ws_d && !mic_ws)
            begin
                mic_pos = 0;                                  // Left slot begins
                if (mic_q.size() > 0)
                    mic_word = mic_q.pop_front();             // Else last word repeats
            end
            else if (mic_pos < 63)
                mic_pos++;
            mic_sd <= (mic_pos >= 1 && mic_pos <= 24) ? mic_word[24 - mic_pos] : 1'b0;
        end
        mic_sck_d = mic_sck;
        mic_ws_d  = mic_ws;
    end

    // --------------------
    // DAC monitor collecting left words from periods 1 to 16
    always @(posedge clk)
    begin
        if (bclk_d && !dac_bclk)
            dac_per = (lrclk_d && !dac_lrclk) ? 0 : dac_per + 1;
        if (!bclk_d && dac_bclk && dac_per >= 1 && dac_per <= 16)
        begin
            dac_sh = {dac_sh[14:0], dac_sdata};               // MSB first
            if (dac_per == 16)
                dac_q.push_back(dac_sh);
        end
        bclk_d  = dac_bclk;
        lrclk_d = dac_lrclk;
    end

    // --------------------
    // TM1638 model
    always @(posedge clk)
    begin
        if (stb_d && !tm_stb)
        begin
            tm_nbits  = 0;                                    // New command
            tm_nbytes = 0;
            tm_rd     = 1'b0;
        end
        if (!tm_stb && !tm_clk_d && tm_clk && !tm_rd)
        begin
            tm_sh = {tm_dio, tm_sh[7:1]};                     // LSB first
            tm_nbits++;
            if (tm_nbits == 8)
            begin
                if (tm_nbytes < 17)
                    tm_bytes[tm_nbytes] = tm_sh;
                tm_nbytes++;
                tm_nbits = 0;
                if (tm_nbytes == 1 && tm_sh == 8'h42)
                begin
                    tm_rd  = 1'b1;                            // Key bytes follow
                    rd_cnt = 0;
                end
            end
        end
        if (!tm_stb && tm_clk_d && !tm_clk && tm_rd && rd_cnt < 32)
        begin
            tm_oe   <= 1'b1;
            tm_dout <= key_bytes[rd_cnt / 8][rd_cnt % 8];
            rd_cnt++;
        end
        if (!stb_d && tm_stb)
        begin
            tm_oe <= 1'b0;
            if (tm_nbytes == 17 && tm_bytes[0] == 8'hC0)
            begin
                for (int i = 0; i < 16; i++)
                    scan_mem[i] = tm_bytes[i + 1];
                scan_cnt++;                                   // Display write done
            end
        end
        stb_d    = tm_stb;
        tm_clk_d = tm_clk;
    end

    // --------------------
    // Expected values

    function automatic logic [15:0] ref_beat(input logic [23:0] w, input logic [2:0] s);
        int v;
        v = $signed(w[23:8]);
        v = v >>> s[1:0];                                     // Attenuate
        if (s[2])
        begin
            v = v * 2;
            if (v > 32767)
                v = 32767;
            else if (v < -32768)
                v = -32768;
        end
        return v[15:0];
    endfunction

    // Segment byte of digit d with a back in MSB
    function automatic logic [7:0] digit_seg(input int d);
        logic [7:0] b;
        logic [7:0] r;
        b = scan_mem[2 * (7 - d)];
        for (int i = 0; i < 8; i++)
            r[i] = b[7 - i];
        return r;
    endfunction

    function automatic int seg_to_hex(input logic [7:0] s);
        for (int h = 0; h < 16; h++)
            if (seg_tab[h] == s)
                return h;
        return -1;                                            // Not a hex digit
    endfunction

    function automatic int scan_ticks();
        int v;
        int h;
        v = 0;
        for (int d = 3; d >= 0; d--)
        begin
            h = seg_to_hex(digit_seg(d));
            if (h < 0)
                return -1;
            v = v * 16 + h;
        end
        return v;
    endfunction

    function automatic logic [7:0] scan_leds();
        logic [7:0] l;
        for (int i = 0; i < 8; i++)
            l[i] = scan_mem[2 * (7 - i) + 1][0];              // Odd addresses
        return l;
    endfunction

    // --------------------
    // Checking and reporting

    task automatic finish_run();
        if (!finished)
        begin
            finished = 1'b1;
            $display("Checks %0d, errors %0d", chk_cnt, err_cnt);
            if (err_cnt == 0 && !timed_out)
                $display("** PASS **");
            else
                $display("** FAIL **");
            $finish;
        end
    endtask

    task automatic abort_on_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        timed_out = 1'b1;
        finish_run();
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (!finished)
        begin
            chk_cnt++;
            if (got !== exp)
            begin
                err_cnt++;
                $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            end
        end
    endtask

    task automatic report(input string name, input int err0);
        if (!finished)
        begin
            if (err_cnt == err0)
                $display("%-16s ok", name);
            else
                $display("%-16s %0d errors", name, err_cnt - err0);
        end
    endtask

    // --------------------
    // Waits

    task automatic wait_mic_drained();
        int t;
        t = 0;
        while (mic_q.size() != 0 && t < 20000)
        begin
            @(posedge clk);
            t++;
        end
        if (mic_q.size() != 0)
            abort_on_timeout("the microphone queue to drain");
    endtask

    task automatic wait_ws_rise();
        int   t;
        logic prev;
        t    = 0;
        prev = 1'b1;
        while (!(!prev && mic_ws) && t < 3000)
        begin
            prev = mic_ws;
            @(posedge clk);
            t++;
        end
        if (t >= 3000)
            abort_on_timeout("a rising mic_ws");
    endtask

    task automatic wait_scans(input int n);
        int t;
        int start;
        t     = 0;
        start = scan_cnt;
        while (scan_cnt < start + n && t < 6000 * n)
        begin
            @(posedge clk);
            t++;
        end
        if (scan_cnt < start + n)
            abort_on_timeout("a TM1638 scan");
    endtask

    task automatic get_dac_word(output logic [15:0] got);
        int t;
        t = 0;
        while (dac_q.size() == 0 && t < 3000)
        begin
            @(posedge clk);
            t++;
        end
        if (dac_q.size() == 0)
        begin
            got = 'x;
            abort_on_timeout("a DAC word");
        end
        else
            got = dac_q.pop_front();
    endtask

    // --------------------
    // Tests

    task automatic clocks_test();
        logic m;
        int   toggles;
        int   err0;
        err0    = err_cnt;
        toggles = 0;
        check("mic_lr", mic_lr, 0);                           // Left channel select
        for (int i = 0; i < 8; i++)
        begin
            m = dac_mclk;
            @(negedge clk);
            if ((dac_mclk ^ m) === 1'b1)
                toggles++;                                    // clk / 2 flips every cycle
        end
        check("dac_mclk toggles", toggles, 8);
        report("clocks", err0);
    endtask

    task automatic audio_test(input logic [2:0] s);
        logic [23:0] w;
        logic [15:0] exp_q[$];
        logic [15:0] got;
        logic [15:0] prev;
        logic        found;
        logic        bad;
        int          skips;
        int          err0;
        err0 = err_cnt;
        prev = '0;
        wait_mic_drained();
        wait_ws_rise();                                       // Old word already taken
        sw <= {1'b0, s};
        dac_q.delete();
        for (int i = 0; i < 5; i++)
        begin
            w = 24'($random(seed));
            mic_q.push_back(w);
            exp_q.push_back(ref_beat(w, s));
        end
        for (int i = 0; i < 5; i++)
        begin
            skips = 0;
            found = 1'b0;
            bad   = 1'b0;
            while (!found && !bad)
            begin
                get_dac_word(got);
                if (got === exp_q[i])
                    found = 1'b1;
                else if ((i == 0 || got === prev) && skips < 6)
                    skips++;                                  // Stale word or repeat
                else
                    bad = 1'b1;
            end
            check($sformatf("dac_sdata sw=%0d", s), got, exp_q[i]);
            prev = exp_q[i];
        end
        report($sformatf("audio sw=%0d", s), err0);
    endtask

    task automatic display_test();
        logic [23:0] w;
        int          err0;
        err0 = err_cnt;
        w    = 24'($random(seed));
        mic_q.push_back(w);
        wait_mic_drained();
        wait_ws_rise();
        wait_scans(2);
        for (int d = 4; d < 8; d++)
            check($sformatf("tm_dio digit %0d", d), digit_seg(d),
                  seg_tab[w[8 + (d - 4) * 4 +: 4]]);
        report("display", err0);
    endtask

    task automatic tick_test();
        int base;
        int got;
        int exp;
        int n;
        int err0;
        err0 = err_cnt;
        n    = 37;
        wait_scans(2);
        base = scan_ticks();
        for (int i = 0; i < n; i++)
        begin
            repeat (4) @(negedge clk);
            force dut_i.slow_clk = 1'b1;                      // Fast stand-in for slow_clk
            repeat (4) @(negedge clk);
            force dut_i.slow_clk = 1'b0;
        end
        release dut_i.slow_clk;
        @(posedge clk);
        wait_scans(2);
        got = scan_ticks();
        exp = (base + n) % 65536;
        if (got == exp + 1 || got == exp - 1)
            exp = got;                                        // Scan may trail the counter
        check("tm_dio tick count", got, exp);
        report("ticks", err0);
    endtask

    task automatic keys_test();
        logic [7:0] kv;
        logic [7:0] exp;
        logic [1:0] kb;
        int         err0;
        err0 = err_cnt;
        for (int i = 0; i < 4; i++)
        begin
            kv = 8'($random(seed));
            kb = 2'($random(seed));
            for (int j = 0; j < 4; j++)
                key_bytes[j] <= {3'b0, kv[j + 4], 3'b0, kv[j]};   // Keys j and j+4
            key <= kb;
            exp = kv | {6'b0, ~kb};
            wait_scans(2);
            check("led", led, exp);
            check("tm_dio leds", scan_leds(), exp);
        end
        report("keys", err0);
    endtask

    // --------------------
    // Sequence

    initial
    begin
        int err0;
        clk     = 1'b0;
        rst     = 1'b1;
        key     = '1;                                         // Nothing pressed
        sw      = '0;
        mic_sd  = 1'b0;
        tm_oe   = 1'b0;
        tm_dout = 1'b0;
        for (int i = 0; i < 4; i++)
            key_bytes[i] = '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        err0 = err_cnt;
        check("led", led, 0);
        check("tm_stb", tm_stb, 1);
        check("dac_lrclk", dac_lrclk, 0);
        report("reset", err0);
        clocks_test();
        @(posedge clk);
        for (int s = 0; s < 8; s++)
            audio_test(3'(s));
        display_test();
        tick_test();
        keys_test();
        finish_run();
    end

endmodule

//--- files.f
+incdir+.
board_pkg.sv
audio_pkg.sv
slow_clk_gen.sv
inmp441_mic_i2s_receiver.sv
i2s_audio_out.sv
tm1638_board_controller.sv
lab_top.sv
board_top.sv
tb_board_top.sv

//--- Makefile
# Verilator simulation of the board wrapper

VERILATOR ?= verilator
TOP       ?= tb_board_top
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= ** PASS **
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -Wno-fatal

.PHONY: sim clean

# Build, run, then look for the pass line in the log
sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qF '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
